//--- rtl/svc_pkg.sv
// Test service command definitions

package svc_pkg;

  // ------------------------------------------------------------------
  // Command bytes
  // ------------------------------------------------------------------

  typedef logic [7:0] svc_code_t;

  localparam svc_code_t CMD_AWUSER_CORE     = 8'h01;
  localparam svc_code_t CMD_AWUSER_MCU      = 8'h02;
  localparam svc_code_t CMD_AWUSER_RELEASE  = 8'h03;
  localparam svc_code_t CMD_ZEROIZE_SET     = 8'h04;
  localparam svc_code_t CMD_ZEROIZE_CLEAR   = 8'h05;
  localparam svc_code_t CMD_ZEROIZE_RELEASE = 8'h06;
  localparam svc_code_t CMD_FORCE_TOKENS    = 8'h07;
  localparam svc_code_t CMD_ALLOW_RMA_SCRAP = 8'h08;
  localparam svc_code_t CMD_ESCALATE        = 8'h09;
  localparam svc_code_t CMD_CLK_500         = 8'h0A;
  localparam svc_code_t CMD_CLK_160         = 8'h0B;
  localparam svc_code_t CMD_CLK_400         = 8'h0C;
  localparam svc_code_t CMD_CLK_1000        = 8'h0D;
  localparam svc_code_t CMD_FC_LCC_RESET    = 8'h10;

  // Mailbox word, cmd0 is issued first and count says how many bytes are valid
  typedef struct packed {
    logic [5:0] rsvd;
    logic [1:0] count;
    svc_code_t  cmd2;
    svc_code_t  cmd1;
    svc_code_t  cmd0;
  } svc_word_t;

  // ------------------------------------------------------------------
  // Override levels
  // ------------------------------------------------------------------

  typedef enum logic [1:0] {
    AWUSER_NONE = 2'd0,
    AWUSER_CORE = 2'd1,
    AWUSER_MCU  = 2'd2
  } awuser_ovr_e;

  typedef enum logic [1:0] {
    ZEROIZE_NONE  = 2'd0,
    ZEROIZE_SET   = 2'd1,
    ZEROIZE_CLEAR = 2'd2
  } zeroize_ovr_e;

  // Encoding matches the external clock mux select
  typedef enum logic [1:0] {
    FREQ_500  = 2'd0,
    FREQ_160  = 2'd1,
    FREQ_400  = 2'd2,
    FREQ_1000 = 2'd3
  } clk_freq_e;

  typedef struct packed {
    awuser_ovr_e  awuser;
    zeroize_ovr_e zeroize;
    logic         tokens_forced;
    logic         rma_scrap_ppd;
    logic         escalate;
    clk_freq_e    clk_freq;
  } svc_ctrl_t;

  // No overrides active and the external clock at 500 MHz
  localparam svc_ctrl_t SVC_CTRL_RESET = '0;

  localparam int SVC_FIFO_DEPTH = 4;
  localparam int SVC_RST_HOLD   = 11;
  localparam int SVC_UNK_W      = 8;

endpackage

//--- rtl/svc_mbox_unpacker.sv
// Mailbox word unpacker

`timescale 1ns/1ns

module svc_mbox_unpacker import svc_pkg::*; (
  input  logic      clk,
  input  logic      cptra_rst_b,
  input  logic      mbox_wr_i,
  input  svc_word_t mbox_word_i,
  input  logic      full_i,
  output logic      push_o,
  output svc_code_t push_code_o,
  output logic      pending_o,
  output logic      drop_o
);

  // Bytes still to be sent, entry 0 is the next one out
  svc_code_t [2:0] bytes_q;
  logic [1:0]      remain_q;
  logic            drop_q;
  logic            accept;

  assign pending_o = (remain_q != 2'd0);

  // A new word is only taken once the previous one is fully unpacked
  assign accept = mbox_wr_i && !pending_o;

  // Hold the current byte while the FIFO has no room
  assign push_o      = pending_o && !full_i;
  assign push_code_o = bytes_q[0];
  assign drop_o      = drop_q;

  // ------------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------------

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      remain_q <= 2'd0;
      drop_q   <= 1'b0;
    end else begin
      if (accept) begin
        // A count of zero leaves the unpacker idle
        remain_q <= mbox_word_i.count;
      end else if (push_o) begin
        remain_q <= remain_q - 2'd1;
      end
      if (mbox_wr_i && pending_o) begin
        drop_q <= 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // Byte shifter
  // ------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      bytes_q <= {mbox_word_i.cmd2, mbox_word_i.cmd1, mbox_word_i.cmd0};
    end else if (push_o) begin
      bytes_q <= {svc_code_t'(8'h00), bytes_q[2:1]};
    end
  end

  // The FIFO never sees a push it cannot store
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    push_o |-> !full_i
  );

  // A stalled byte is presented unchanged until it goes out
  a_hold_on_full: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    (pending_o && full_i) |=> (pending_o && $stable(push_code_o))
  );

endmodule

//--- rtl/svc_cmd_fifo.sv
// Command byte FIFO

`timescale 1ns/1ns

module svc_cmd_fifo import svc_pkg::*; #(
  parameter int DEPTH = SVC_FIFO_DEPTH
) (
  input  logic      clk,
  input  logic      cptra_rst_b,
  input  logic      push_i,
  input  svc_code_t push_code_i,
  input  logic      pop_i,
  output svc_code_t head_code_o,
  output logic      empty_o,
  output logic      full_o
);

  svc_code_t mem [DEPTH];

  // Pointers wrap on their own since DEPTH is a power of two
  logic [$clog2(DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(DEPTH):0]   count_q;

  // Show-ahead, the oldest entry is always on the output
  assign head_code_o = mem[rd_ptr_q];
  assign empty_o     = (count_q == '0);
  assign full_o      = (count_q == ($clog2(DEPTH) + 1)'(DEPTH));

  // ------------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------------

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count unchanged
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_code_i;
    end
  end

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    push_i |-> !full_o
  );

  a_no_underflow: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    pop_i |-> !empty_o
  );

endmodule

//--- rtl/svc_cmd_decoder.sv
// Command decoder and override register

`timescale 1ns/1ns

module svc_cmd_decoder import svc_pkg::*; (
  input  logic                 clk,
  input  logic                 cptra_rst_b,
  input  svc_code_t            head_code_i,
  input  logic                 empty_i,
  input  logic                 rst_active_i,
  output logic                 pop_o,
  output svc_ctrl_t            ctrl_o,
  output logic                 rst_req_o,
  output logic [SVC_UNK_W-1:0] unknown_cnt_o
);

  svc_ctrl_t            ctrl_q;
  svc_ctrl_t            ctrl_d;
  logic [SVC_UNK_W-1:0] unk_cnt_q;
  logic                 unk_hit;

  // Commands wait while the fuse and lifecycle controllers are held in reset
  assign pop_o = !empty_i && !rst_active_i;

  // The request goes out in the pop cycle so the stretcher blocks the next pop
  assign rst_req_o = pop_o && (head_code_i == CMD_FC_LCC_RESET);

  assign ctrl_o        = ctrl_q;
  assign unknown_cnt_o = unk_cnt_q;

  // ------------------------------------------------------------------
  // Command decode
  // ------------------------------------------------------------------

  always_comb begin
    ctrl_d  = ctrl_q;
    unk_hit = 1'b0;
    case (head_code_i)
      CMD_AWUSER_CORE:     ctrl_d.awuser        = AWUSER_CORE;
      CMD_AWUSER_MCU:      ctrl_d.awuser        = AWUSER_MCU;
      CMD_AWUSER_RELEASE:  ctrl_d.awuser        = AWUSER_NONE;
      CMD_ZEROIZE_SET:     ctrl_d.zeroize       = ZEROIZE_SET;
      CMD_ZEROIZE_CLEAR:   ctrl_d.zeroize       = ZEROIZE_CLEAR;
      CMD_ZEROIZE_RELEASE: ctrl_d.zeroize       = ZEROIZE_NONE;
      CMD_FORCE_TOKENS:    ctrl_d.tokens_forced = 1'b1;
      CMD_ALLOW_RMA_SCRAP: ctrl_d.rma_scrap_ppd = 1'b1;
      CMD_ESCALATE:        ctrl_d.escalate      = 1'b1;
      CMD_CLK_500:         ctrl_d.clk_freq      = FREQ_500;
      CMD_CLK_160:         ctrl_d.clk_freq      = FREQ_160;
      CMD_CLK_400:         ctrl_d.clk_freq      = FREQ_400;
      CMD_CLK_1000:        ctrl_d.clk_freq      = FREQ_1000;
      CMD_FC_LCC_RESET: begin
        // Handled by the reset request, no level changes
        ctrl_d = ctrl_q;
      end
      default: begin
        unk_hit = 1'b1;
      end
    endcase
  end

  // ------------------------------------------------------------------
  // Sticky state
  // ------------------------------------------------------------------

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      ctrl_q    <= SVC_CTRL_RESET;
      unk_cnt_q <= '0;
    end else if (pop_o) begin
      ctrl_q <= ctrl_d;
      // Counter stops at all ones
      if (unk_hit && (unk_cnt_q != '1)) begin
        unk_cnt_q <= unk_cnt_q + 1'b1;
      end
    end
  end

  a_no_req_in_reset: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    rst_req_o |-> !rst_active_i
  );

  // Every request is taken up by the stretcher on the next cycle
  a_req_starts_pulse: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    rst_req_o |=> rst_active_i
  );

endmodule

//--- rtl/svc_reset_stretcher.sv
// Fuse and lifecycle reset stretcher

`timescale 1ns/1ns

module svc_reset_stretcher import svc_pkg::*; (
  input  logic clk,
  input  logic cptra_rst_b,
  input  logic req_i,
  output logic active_o,
  output logic rst_b_o
);

  logic [$clog2(SVC_RST_HOLD)-1:0] cnt_q;
  logic                            active_q;
  logic                            active_d;
  logic                            rst_b_q;

  // Next active level, the last hold cycle is the one with the count at zero
  always_comb begin
    active_d = active_q;
    if (!active_q && req_i) begin
      active_d = 1'b1;
    end else if (active_q && (cnt_q == '0)) begin
      active_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      cnt_q    <= '0;
      active_q <= 1'b0;
      rst_b_q  <= 1'b1;
    end else begin
      active_q <= active_d;
      // Registered so the reset output is free of glitches
      rst_b_q  <= !active_d;
      if (!active_q && req_i) begin
        cnt_q <= $bits(cnt_q)'(SVC_RST_HOLD - 1);
      end else if (active_q && (cnt_q != '0)) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign active_o = active_q;
  assign rst_b_o  = rst_b_q;

  a_pulse_length: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    $rose(active_o) |-> (active_o && !rst_b_o) [*SVC_RST_HOLD] ##1 !active_o
  );

endmodule

//--- rtl/svc_top.sv
// Test service command block

`timescale 1ns/1ns

module svc_top import svc_pkg::*; (
  input  logic                 clk,
  input  logic                 cptra_rst_b,
  input  logic                 mbox_wr_i,
  input  svc_word_t            mbox_word_i,
  output svc_ctrl_t            ctrl_o,
  output logic                 fc_lcc_rst_b_o,
  output logic [SVC_UNK_W-1:0] unknown_cnt_o,
  output logic                 drop_o,
  output logic                 busy_o
);

  // Unpacker to FIFO
  logic      push;
  svc_code_t push_code;
  logic      full;
  logic      pending;

  // FIFO to decoder
  svc_code_t head_code;
  logic      empty;
  logic      pop;

  // Decoder to stretcher
  logic      rst_req;
  logic      rst_active;

  svc_mbox_unpacker u_unpacker (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .mbox_wr_i   (mbox_wr_i),
    .mbox_word_i (mbox_word_i),
    .full_i      (full),
    .push_o      (push),
    .push_code_o (push_code),
    .pending_o   (pending),
    .drop_o      (drop_o)
  );

  svc_cmd_fifo #(
    .DEPTH (SVC_FIFO_DEPTH)
  ) u_fifo (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .push_i      (push),
    .push_code_i (push_code),
    .pop_i       (pop),
    .head_code_o (head_code),
    .empty_o     (empty),
    .full_o      (full)
  );

  svc_cmd_decoder u_decoder (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .head_code_i   (head_code),
    .empty_i       (empty),
    .rst_active_i  (rst_active),
    .pop_o         (pop),
    .ctrl_o        (ctrl_o),
    .rst_req_o     (rst_req),
    .unknown_cnt_o (unknown_cnt_o)
  );

  svc_reset_stretcher u_rst_stretch (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .req_i       (rst_req),
    .active_o    (rst_active),
    .rst_b_o     (fc_lcc_rst_b_o)
  );

  // Work is outstanding while bytes wait in either stage
  assign busy_o = pending || !empty;

endmodule

//--- tb/svc_tb.sv
// Test service command block testbench

`timescale 1ns/1ns

module svc_tb import svc_pkg::*; ();

  localparam int N_CMDS    = 69;
  localparam int MAX_CYCLE = N_CMDS * 20 + 200;

  logic                 clk;
  logic                 cptra_rst_b;
  logic                 mbox_wr_i;
  svc_word_t            mbox_word_i;
  svc_ctrl_t            ctrl_o;
  logic                 fc_lcc_rst_b_o;
  logic [SVC_UNK_W-1:0] unknown_cnt_o;
  logic                 drop_o;
  logic                 busy_o;

  // Reference model state
  svc_ctrl_t            exp_ctrl;
  logic [SVC_UNK_W-1:0] exp_unk;
  logic                 exp_drop;
  int                   exp_pulses;

  // snap[0] is the state before a write, snap[k] the state after its byte k-1
  svc_ctrl_t   snap [4];
  logic [1:0]  chk_mode;
  string       test_name;
  logic [15:0] lfsr;
  svc_code_t   code_tab [16];
  int          errors;
  int          pulses;
  int          cycles;
  logic        rst_b_prev;

  svc_top uut (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .mbox_wr_i      (mbox_wr_i),
    .mbox_word_i    (mbox_word_i),
    .ctrl_o         (ctrl_o),
    .fc_lcc_rst_b_o (fc_lcc_rst_b_o),
    .unknown_cnt_o  (unknown_cnt_o),
    .drop_o         (drop_o),
    .busy_o         (busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  a_single_timing: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    (mbox_wr_i && chk_mode == 2'd1) |=> (ctrl_o == snap[0]) [*2] ##1 (ctrl_o == snap[1])
  ) else begin
    errors++;
    $display("error %s expected %h actual %h", test_name, snap[1], ctrl_o);
  end

  a_byte_order: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    (mbox_wr_i && chk_mode == 2'd2) |=> (ctrl_o == snap[0]) [*2] ##1 (ctrl_o == snap[1])
      ##1 (ctrl_o == snap[2]) ##1 (ctrl_o == snap[3])
  ) else begin
    errors++;
    $display("error %s expected %h actual %h", test_name, snap[3], ctrl_o);
  end

  // A write that carries bytes leaves work outstanding on the next cycle
  a_busy_after_write: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    (mbox_wr_i && mbox_word_i.count != 2'd0) |=> busy_o
  ) else begin
    errors++;
    $display("Busy stayed low after a write with bytes in %s", test_name);
  end

  // Once all queued work has drained the outputs must match the model
  a_drained_state: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    $fell(busy_o) |-> ({ctrl_o, unknown_cnt_o, drop_o} == {exp_ctrl, exp_unk, exp_drop})
  ) else begin
    errors++;
    $display("error %s expected %h actual %h", test_name,
             {exp_ctrl, exp_unk, exp_drop}, {ctrl_o, unknown_cnt_o, drop_o});
  end

  a_pulse_width: assert property (
    @(posedge clk) disable iff (!cptra_rst_b)
    $fell(fc_lcc_rst_b_o) |-> (!fc_lcc_rst_b_o) [*SVC_RST_HOLD] ##1 fc_lcc_rst_b_o
  ) else begin
    errors++;
    $display("Fuse and lifecycle reset in %s was not low for %0d cycles", test_name,
             SVC_RST_HOLD);
  end

  always @(negedge clk) begin
    if (cptra_rst_b && rst_b_prev && !fc_lcc_rst_b_o) begin
      pulses = pulses + 1;
    end
    rst_b_prev = fc_lcc_rst_b_o;
    cycles = cycles + 1;
    if (cycles == MAX_CYCLE) begin
      $display("Timeout after %0d cycles, the design never went idle", MAX_CYCLE);
      $display("Simulation failed");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // Reference model and stimulus helpers
  // ------------------------------------------------------------------

  task automatic model_byte(input svc_code_t code);
    case (code)
      CMD_AWUSER_CORE:     exp_ctrl.awuser = AWUSER_CORE;
      CMD_AWUSER_MCU:      exp_ctrl.awuser = AWUSER_MCU;
      CMD_AWUSER_RELEASE:  exp_ctrl.awuser = AWUSER_NONE;
      CMD_ZEROIZE_SET:     exp_ctrl.zeroize = ZEROIZE_SET;
      CMD_ZEROIZE_CLEAR:   exp_ctrl.zeroize = ZEROIZE_CLEAR;
      CMD_ZEROIZE_RELEASE: exp_ctrl.zeroize = ZEROIZE_NONE;
      CMD_FORCE_TOKENS:    exp_ctrl.tokens_forced = 1'b1;
      CMD_ALLOW_RMA_SCRAP: exp_ctrl.rma_scrap_ppd = 1'b1;
      CMD_ESCALATE:        exp_ctrl.escalate = 1'b1;
      CMD_CLK_500:         exp_ctrl.clk_freq = FREQ_500;
      CMD_CLK_160:         exp_ctrl.clk_freq = FREQ_160;
      CMD_CLK_400:         exp_ctrl.clk_freq = FREQ_400;
      CMD_CLK_1000:        exp_ctrl.clk_freq = FREQ_1000;
      CMD_FC_LCC_RESET:    exp_pulses = exp_pulses + 1;
      default: begin
        if (exp_unk != '1) begin
          exp_unk = exp_unk + 1'b1;
        end
      end
    endcase
  endtask

  // Called on a falling edge, returns on the next one with the strobe low
  task automatic drive_word(input logic [1:0] cnt, input svc_code_t c0, input svc_code_t c1,
                            input svc_code_t c2, input logic lost, input logic [1:0] mode);
    svc_code_t codes [3];
    codes[0] = c0;
    codes[1] = c1;
    codes[2] = c2;
    snap[0] = exp_ctrl;
    mbox_wr_i = 1'b1;
    mbox_word_i = '{rsvd: 6'd0, count: cnt, cmd2: c2, cmd1: c1, cmd0: c0};
    chk_mode = mode;
    if (lost) begin
      exp_drop = 1'b1;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (i < int'(cnt)) begin
          model_byte(codes[i]);
        end
        snap[i+1] = exp_ctrl;
      end
    end
    @(negedge clk);
    mbox_wr_i = 1'b0;
    chk_mode = 2'd0;
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (busy_o || !fc_lcc_rst_b_o) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[6:0], lfsr[0]};
      lfsr = next_lfsr(lfsr);
    end
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------

  initial begin
    logic [7:0] r;
    logic [1:0] cnt;
    svc_code_t  c0;
    svc_code_t  c1;
    svc_code_t  c2;
    cptra_rst_b = 1'b0;
    mbox_wr_i = 1'b0;
    mbox_word_i = '0;
    chk_mode = 2'd0;
    exp_ctrl = '0;
    exp_unk = '0;
    exp_drop = 1'b0;
    exp_pulses = 0;
    errors = 0;
    pulses = 0;
    cycles = 0;
    rst_b_prev = 1'b1;
    lfsr = 16'd73;
    // Every defined code, the reset command, then two unknown codes
    // The 500 MHz select follows the 1000 MHz one so that it moves the field
    code_tab = '{8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07, 8'h08,
                 8'h09, 8'h0B, 8'h0C, 8'h0D, 8'h0A, 8'h10, 8'h5A, 8'hC3};
    repeat (10) @(negedge clk);
    cptra_rst_b = 1'b1;
    @(negedge clk);

    test_name = "single";
    for (int k = 0; k < 14; k++) begin
      drive_word(2'd1, code_tab[k], 8'h00, 8'h00, 1'b0, 2'd1);
      wait_idle();
    end
    test_name = "unknown";
    drive_word(2'd1, code_tab[14], 8'h00, 8'h00, 1'b0, 2'd1);
    wait_idle();
    drive_word(2'd1, 8'hFF, 8'h00, 8'h00, 1'b0, 2'd1);
    wait_idle();

    test_name = "order";
    drive_word(2'd3, CMD_AWUSER_MCU, CMD_ZEROIZE_CLEAR, CMD_CLK_160, 1'b0, 2'd2);
    wait_idle();

    test_name = "reset_pair";
    drive_word(2'd2, CMD_FC_LCC_RESET, CMD_FC_LCC_RESET, 8'h00, 1'b0, 2'd0);
    wait_idle();

    // The second word lands while the reset holds the FIFO, so the unpacker stalls on full
    test_name = "backpressure";
    drive_word(2'd3, CMD_FC_LCC_RESET, CMD_AWUSER_CORE, CMD_CLK_400, 1'b0, 2'd0);
    repeat (3) @(negedge clk);
    drive_word(2'd3, CMD_ZEROIZE_SET, CMD_CLK_500, CMD_AWUSER_RELEASE, 1'b0, 2'd0);
    wait_idle();

    test_name = "drop";
    drive_word(2'd3, CMD_CLK_160, CMD_ZEROIZE_RELEASE, CMD_AWUSER_MCU, 1'b0, 2'd0);
    drive_word(2'd3, CMD_CLK_1000, 8'h55, CMD_AWUSER_CORE, 1'b1, 2'd0);
    wait_idle();

    test_name = "random";
    for (int w = 0; w < 12; w++) begin
      take_bits(2, r);
      cnt = r[1:0];
      take_bits(4, r);
      c0 = code_tab[r[3:0]];
      take_bits(4, r);
      c1 = code_tab[r[3:0]];
      take_bits(4, r);
      c2 = code_tab[r[3:0]];
      drive_word(cnt, c0, c1, c2, 1'b0, 2'd0);
      wait_idle();
    end

    test_name = "final";
    a_final_state: assert ({ctrl_o, unknown_cnt_o, drop_o} == {exp_ctrl, exp_unk, exp_drop})
    else begin
      errors++;
      $display("error %s expected %h actual %h", test_name,
               {exp_ctrl, exp_unk, exp_drop}, {ctrl_o, unknown_cnt_o, drop_o});
    end
    a_pulse_count: assert (pulses == exp_pulses) else begin
      errors++;
      $display("error pulse_count expected %0d actual %0d", exp_pulses, pulses);
    end
    $display("Run ended after %0d cycles, %0d reset pulses, %0d errors", cycles, pulses,
             errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tb.f
rtl/svc_pkg.sv
rtl/svc_mbox_unpacker.sv
rtl/svc_cmd_fifo.sv
rtl/svc_cmd_decoder.sv
rtl/svc_reset_stretcher.sv
rtl/svc_top.sv
tb/svc_tb.sv

//--- Makefile
# Verilator build and run for the test service command block

VERILATOR ?= verilator
TOP       ?= svc_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
